// ==== gfx_defines.svh ====
// gfx defines: screen, coordinate, depth, color and edge widths for the renderer
`ifndef GFX_DEFINES_SVH
`define GFX_DEFINES_SVH

// framebuffer size in pixels
`define GFX_HRES 32
`define GFX_VRES 32

// screen coordinate widths
`define GFX_XW 5
`define GFX_YW 5

`define GFX_ZW 8   // depth
`define GFX_CW 8   // flat color

// framebuffer word address, log2(HRES*VRES)
`define GFX_AW 10

// signed edge function value, holds +-2*31*31
`define GFX_EW 13

// depth written by a clear, farthest possible
`define GFX_ZMAX {`GFX_ZW{1'b1}}

`endif

// ==== gfx_pkg.sv ====
// gfx package: triangle, job, fragment and framebuffer types plus the shared edge function
`default_nettype none
`include "gfx_defines.svh"

package gfx_pkg;

  typedef struct packed {
    logic [`GFX_XW-1:0] x;
    logic [`GFX_YW-1:0] y;
    logic [`GFX_ZW-1:0] z;
  } vertex_t;

  typedef struct packed {
    vertex_t [2:0]      v;
    logic [`GFX_CW-1:0] color;
  } triangle_t;

  // triangle after setup, ccw winding, box already clipped
  typedef struct packed {
    logic [2:0][`GFX_XW-1:0] x;
    logic [2:0][`GFX_YW-1:0] y;
    logic [`GFX_XW-1:0]      xmin;
    logic [`GFX_XW-1:0]      xmax;
    logic [`GFX_YW-1:0]      ymin;
    logic [`GFX_YW-1:0]      ymax;
    logic [`GFX_ZW-1:0]      z;
    logic [`GFX_CW-1:0]      color;
  } raster_job_t;

  typedef struct packed {
    logic [`GFX_AW-1:0] addr;
    logic [`GFX_ZW-1:0] z;
    logic [`GFX_CW-1:0] color;
    logic               covered;
    logic               last;
  } fragment_t;

  typedef struct packed {
    logic [`GFX_ZW-1:0] z;
    logic [`GFX_CW-1:0] color;
  } fb_word_t;

  typedef struct packed {
    logic [`GFX_AW-1:0] addr;
    logic               we;
    fb_word_t           wdata;
  } fb_req_t;

  // edge a->b evaluated at p, positive on the left of a ccw edge
  function automatic logic signed [`GFX_EW-1:0] edge_val(
    input logic [`GFX_XW-1:0] ax,
    input logic [`GFX_YW-1:0] ay,
    input logic [`GFX_XW-1:0] bx,
    input logic [`GFX_YW-1:0] by,
    input logic [`GFX_XW-1:0] px,
    input logic [`GFX_YW-1:0] py
  );
    logic signed [`GFX_EW-1:0] sax, say, sbx, sby, spx, spy;
    sax = ax;  // zero extended
    say = ay;
    sbx = bx;
    sby = by;
    spx = px;
    spy = py;
    return (sbx - sax) * (spy - say) - (sby - say) * (spx - sax);
  endfunction

endpackage

`default_nettype wire

// ==== tri_setup.sv ====
// triangle setup: ccw winding fix, degenerate marking, clipped bounding box and flat depth
`timescale 1ns/10ps
`default_nettype none
`include "gfx_defines.svh"

module tri_setup (
  input  logic                    clk_in,
  input  logic                    rst,
  input  logic                    tri_valid,
  input  gfx_pkg::triangle_t      tri_data,
  output logic                    tri_ready,
  output logic                    job_valid,
  output gfx_pkg::raster_job_t    job,
  input  logic                    job_ready
);

  logic signed [`GFX_EW-1:0] area;
  gfx_pkg::vertex_t          a, b, c;
  gfx_pkg::raster_job_t      next_job;
  int                        xlo, xhi, ylo, yhi;

  function automatic int min3(input int p, input int q, input int r);
    int m;
    m = (p < q) ? p : q;
    return (m < r) ? m : r;
  endfunction

  function automatic int max3(input int p, input int q, input int r);
    int m;
    m = (p > q) ? p : q;
    return (m > r) ? m : r;
  endfunction

  always_comb begin
    area = gfx_pkg::edge_val(tri_data.v[0].x, tri_data.v[0].y, tri_data.v[1].x,
                             tri_data.v[1].y, tri_data.v[2].x, tri_data.v[2].y);
    a = tri_data.v[0];
    b = (area < 0) ? tri_data.v[2] : tri_data.v[1];  // cw input, swap 1 and 2
    c = (area < 0) ? tri_data.v[1] : tri_data.v[2];

    // box clipped to the screen
    xlo = max3(0, 0, min3(a.x, b.x, c.x));
    ylo = max3(0, 0, min3(a.y, b.y, c.y));
    xhi = min3(`GFX_HRES - 1, `GFX_HRES - 1, max3(a.x, b.x, c.x));
    yhi = min3(`GFX_VRES - 1, `GFX_VRES - 1, max3(a.y, b.y, c.y));

    next_job.x     = {c.x, b.x, a.x};
    next_job.y     = {c.y, b.y, a.y};
    next_job.xmin  = `GFX_XW'(xlo);
    next_job.xmax  = `GFX_XW'(xhi);
    next_job.ymin  = `GFX_YW'(ylo);
    next_job.ymax  = `GFX_YW'(yhi);
    next_job.z     = `GFX_ZW'(min3(a.z, b.z, c.z));  // flat depth, nearest vertex
    next_job.color = tri_data.color;

    if (area == 0) begin
      // zero area, empty box so only the last token comes out
      next_job.xmin = `GFX_XW'(`GFX_HRES - 1);
      next_job.xmax = '0;
    end
  end

  assign tri_ready = !job_valid || job_ready;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      job_valid <= 1'b0;
    end else if (tri_ready) begin
      job_valid <= tri_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (tri_valid && tri_ready) begin
      job <= next_job;
    end
  end

  a_job_hold: assert property (@(posedge clk_in) disable iff (rst)
    job_valid && !job_ready |=> job_valid && $stable(job));

endmodule

`default_nettype wire

// ==== tri_raster.sv ====
// rasterizer: walks the job box one pixel per cycle and emits covered fragments
`timescale 1ns/10ps
`default_nettype none
`include "gfx_defines.svh"

module tri_raster (
  input  logic                    clk_in,
  input  logic                    rst,
  input  logic                    job_valid,
  input  gfx_pkg::raster_job_t    job,
  output logic                    job_ready,
  output logic                    frag_valid,
  output gfx_pkg::fragment_t      frag,
  input  logic                    frag_ready
);

  gfx_pkg::raster_job_t      job_q;
  logic                      active;
  logic [`GFX_XW-1:0]        x_cnt;
  logic [`GFX_YW-1:0]        y_cnt;
  logic signed [`GFX_EW-1:0] e0, e1, e2;
  logic                      empty;
  logic                      covered;
  logic                      last_pix;
  logic                      step;

  always_comb begin
    e0 = gfx_pkg::edge_val(job_q.x[0], job_q.y[0], job_q.x[1], job_q.y[1], x_cnt, y_cnt);
    e1 = gfx_pkg::edge_val(job_q.x[1], job_q.y[1], job_q.x[2], job_q.y[2], x_cnt, y_cnt);
    e2 = gfx_pkg::edge_val(job_q.x[2], job_q.y[2], job_q.x[0], job_q.y[0], x_cnt, y_cnt);
  end

  assign empty    = (job_q.xmin > job_q.xmax) || (job_q.ymin > job_q.ymax);
  assign covered  = !empty && (e0 >= 0) && (e1 >= 0) && (e2 >= 0);  // edges inclusive
  assign last_pix = empty || (x_cnt == job_q.xmax && y_cnt == job_q.ymax);

  // uncovered pixels are skipped unless one has to carry last
  assign frag_valid = active && (covered || last_pix);
  assign step       = active && (frag_ready || !frag_valid);
  assign job_ready  = !active;

  always_comb begin
    frag.addr    = `GFX_AW'(y_cnt * `GFX_HRES + x_cnt);
    frag.z       = job_q.z;
    frag.color   = job_q.color;
    frag.covered = covered;
    frag.last    = last_pix;
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      active <= 1'b0;
    end else if (job_valid && job_ready) begin
      active <= 1'b1;
    end else if (step && last_pix) begin
      active <= 1'b0;  // last token gone
    end
  end

  always_ff @(posedge clk_in) begin
    if (job_valid && job_ready) begin
      job_q <= job;
      x_cnt <= job.xmin;
      y_cnt <= job.ymin;
    end else if (step && !last_pix) begin
      if (x_cnt == job_q.xmax) begin
        x_cnt <= job_q.xmin;  // next row
        y_cnt <= y_cnt + 1'b1;
      end else begin
        x_cnt <= x_cnt + 1'b1;
      end
    end
  end

  // nothing more after last until the next job is taken
  a_one_last: assert property (@(posedge clk_in) disable iff (rst)
    frag_valid && frag_ready && frag.last |=> !frag_valid until (job_valid && job_ready));

endmodule

`default_nettype wire

// ==== depth_test.sv ====
// depth test: framebuffer read, strict less-than compare and conditional write per fragment
`timescale 1ns/10ps
`default_nettype none

module depth_test (
  input  logic                  clk_in,
  input  logic                  rst,
  input  logic                  frag_valid,
  input  gfx_pkg::fragment_t    frag,
  output logic                  frag_ready,
  output logic                  req,
  output gfx_pkg::fb_req_t      req_data,
  input  logic                  gnt,
  input  logic                  resp_valid,
  input  gfx_pkg::fb_word_t     resp_data,
  output logic                  draw_done
);

  typedef enum logic [1:0] {st_idle, st_read, st_wait, st_write} state_t;

  state_t             state;
  gfx_pkg::fragment_t frag_q;
  logic               retire_last;

  assign frag_ready = (state == st_idle);
  assign req        = (state == st_read) || (state == st_write);

  always_comb begin
    req_data.addr        = frag_q.addr;
    req_data.we          = (state == st_write);
    req_data.wdata.z     = frag_q.z;
    req_data.wdata.color = frag_q.color;
  end

  // a fragment carrying last leaves the stage this cycle
  always_comb begin
    retire_last = 1'b0;
    case (state)
      st_idle:  retire_last = frag_valid && !frag.covered && frag.last;
      st_wait:  retire_last = resp_valid && (frag_q.z >= resp_data.z) && frag_q.last;
      st_write: retire_last = gnt && frag_q.last;
      default:  retire_last = 1'b0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      state     <= st_idle;
      draw_done <= 1'b0;
    end else begin
      draw_done <= retire_last;
      case (state)
        st_idle: if (frag_valid && frag.covered) state <= st_read;  // token only costs a cycle
        st_read: if (gnt) state <= st_wait;
        st_wait: begin
          if (resp_valid) begin
            state <= (frag_q.z < resp_data.z) ? st_write : st_idle;  // strictly nearer wins
          end
        end
        st_write: if (gnt) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (frag_valid && frag_ready) begin
      frag_q <= frag;
    end
  end

  a_resp_in_wait: assert property (@(posedge clk_in) disable iff (rst)
    resp_valid |-> state == st_wait);

endmodule

`default_nettype wire

// ==== frame_clear.sv ====
// frame clear: writes max depth and the latched color to every framebuffer word
`timescale 1ns/10ps
`default_nettype none
`include "gfx_defines.svh"

module frame_clear (
  input  logic                clk_in,
  input  logic                rst,
  input  logic                clear_start,
  input  logic [`GFX_CW-1:0]  clear_color,
  output logic                busy,
  output logic                req,
  output gfx_pkg::fb_req_t    req_data,
  input  logic                gnt
);

  logic [`GFX_AW-1:0] addr_cnt;
  logic [`GFX_CW-1:0] color_q;

  assign req = busy;

  always_comb begin
    req_data.addr        = addr_cnt;
    req_data.we          = 1'b1;
    req_data.wdata.z     = `GFX_ZMAX;
    req_data.wdata.color = color_q;
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      busy     <= 1'b0;
      addr_cnt <= '0;
    end else if (!busy) begin
      if (clear_start) begin
        busy     <= 1'b1;
        addr_cnt <= '0;
      end
    end else if (gnt) begin
      addr_cnt <= addr_cnt + 1'b1;
      if (addr_cnt == `GFX_AW'(`GFX_HRES * `GFX_VRES - 1)) busy <= 1'b0;  // final word
    end
  end

  always_ff @(posedge clk_in) begin
    if (clear_start && !busy) color_q <= clear_color;
  end

endmodule

`default_nettype wire

// ==== fb_arbiter.sv ====
// framebuffer arbiter: fixed priority clear, depth test, readout, with read data steering
`timescale 1ns/10ps
`default_nettype none

module fb_arbiter (
  input  logic               clk_in,
  input  logic               rst,
  input  logic               clr_req,
  input  logic               dt_req,
  input  logic               rd_req,
  input  gfx_pkg::fb_req_t   clr_data,
  input  gfx_pkg::fb_req_t   dt_data,
  input  gfx_pkg::fb_req_t   rd_data_req,
  output logic               clr_gnt,
  output logic               dt_gnt,
  output logic               rd_gnt,
  output gfx_pkg::fb_req_t   mem_req,
  output logic               mem_en,
  input  gfx_pkg::fb_word_t  mem_rdata,
  output logic               dt_resp_valid,
  output logic               rd_resp_valid,
  output gfx_pkg::fb_word_t  resp_data
);

  assign clr_gnt = clr_req;
  assign dt_gnt  = dt_req && !clr_req;
  assign rd_gnt  = rd_req && !clr_req && !dt_req;
  assign mem_en  = clr_req || dt_req || rd_req;

  always_comb begin
    if (clr_gnt)     mem_req = clr_data;
    else if (dt_gnt) mem_req = dt_data;
    else             mem_req = rd_data_req;
  end

  // owner of the read in flight, data shows up next cycle
  always_ff @(posedge clk_in) begin
    if (rst) begin
      dt_resp_valid <= 1'b0;
      rd_resp_valid <= 1'b0;
    end else begin
      dt_resp_valid <= dt_gnt && !dt_data.we;
      rd_resp_valid <= rd_gnt && !rd_data_req.we;
    end
  end

  assign resp_data = mem_rdata;

  // a peer left waiting keeps its request and data up
  a_dt_hold: assert property (@(posedge clk_in) disable iff (rst)
    dt_req && !dt_gnt |=> dt_req && $stable(dt_data));

  a_rd_hold: assert property (@(posedge clk_in) disable iff (rst)
    rd_req && !rd_gnt |=> rd_req && $stable(rd_data_req));

endmodule

`default_nettype wire

// ==== fb_mem.sv ====
// framebuffer memory: single port, depth plus color words, one-cycle registered read
`timescale 1ns/10ps
`default_nettype none
`include "gfx_defines.svh"

module fb_mem (
  input  logic               clk_in,
  input  logic               en,
  input  gfx_pkg::fb_req_t   req,
  output gfx_pkg::fb_word_t  rdata
);

  gfx_pkg::fb_word_t mem [`GFX_HRES * `GFX_VRES];

  always_ff @(posedge clk_in) begin
    if (en) begin
      if (req.we) begin
        mem[req.addr] <= req.wdata;
      end else begin
        rdata <= mem[req.addr];  // valid the cycle after
      end
    end
  end

endmodule

`default_nettype wire

// ==== gfx_top.sv ====
// renderer top: setup, raster and depth test pipeline sharing one framebuffer with clear and readout
`timescale 1ns/10ps
`default_nettype none
`include "gfx_defines.svh"

module gfx_top (
  input  logic                clk_in,
  input  logic                rst,
  input  logic                tri_valid,
  input  gfx_pkg::triangle_t  tri_data,
  output logic                tri_ready,
  input  logic                clear_start,
  input  logic [`GFX_CW-1:0]  clear_color,
  output logic                clear_busy,
  input  logic                rd_valid,
  input  logic [`GFX_AW-1:0]  rd_addr,
  output logic                rd_ready,
  output logic                rd_data_valid,
  output gfx_pkg::fb_word_t   rd_data,
  output logic                draw_done
);

  logic                  job_valid, job_ready;
  gfx_pkg::raster_job_t  job;
  logic                  frag_valid, frag_ready;
  gfx_pkg::fragment_t    frag;
  logic                  clr_req, dt_req, clr_gnt, dt_gnt, dt_resp_valid;
  gfx_pkg::fb_req_t      clr_data, dt_data, rd_req_data, mem_req;
  logic                  mem_en;
  gfx_pkg::fb_word_t     mem_rdata, resp_data;

  assign rd_req_data = '{addr: rd_addr, we: 1'b0, wdata: '0};  // readout never writes

  tri_setup i_setup (
    .clk_in(clk_in), .rst(rst),
    .tri_valid(tri_valid), .tri_data(tri_data), .tri_ready(tri_ready),
    .job_valid(job_valid), .job(job), .job_ready(job_ready)
  );

  tri_raster i_raster (
    .clk_in(clk_in), .rst(rst),
    .job_valid(job_valid), .job(job), .job_ready(job_ready),
    .frag_valid(frag_valid), .frag(frag), .frag_ready(frag_ready)
  );

  depth_test i_depth (
    .clk_in(clk_in), .rst(rst),
    .frag_valid(frag_valid), .frag(frag), .frag_ready(frag_ready),
    .req(dt_req), .req_data(dt_data), .gnt(dt_gnt),
    .resp_valid(dt_resp_valid), .resp_data(resp_data), .draw_done(draw_done)
  );

  frame_clear i_clear (
    .clk_in(clk_in), .rst(rst),
    .clear_start(clear_start), .clear_color(clear_color), .busy(clear_busy),
    .req(clr_req), .req_data(clr_data), .gnt(clr_gnt)
  );

  fb_arbiter i_arb (
    .clk_in(clk_in), .rst(rst),
    .clr_req(clr_req), .dt_req(dt_req), .rd_req(rd_valid),
    .clr_data(clr_data), .dt_data(dt_data), .rd_data_req(rd_req_data),
    .clr_gnt(clr_gnt), .dt_gnt(dt_gnt), .rd_gnt(rd_ready),
    .mem_req(mem_req), .mem_en(mem_en), .mem_rdata(mem_rdata),
    .dt_resp_valid(dt_resp_valid), .rd_resp_valid(rd_data_valid), .resp_data(resp_data)
  );

  assign rd_data = resp_data;

  fb_mem i_mem (
    .clk_in(clk_in), .en(mem_en), .req(mem_req), .rdata(mem_rdata)
  );

endmodule

`default_nettype wire

// ==== gfx_tb.sv ====
// renderer testbench: table of triangles drawn against a pixel model, full framebuffer readback
`timescale 1ns/10ps
`default_nettype none
`include "gfx_defines.svh"

module gfx_tb;

  localparam int num_entries  = 17;
  localparam int num_clears   = 6;
  localparam int num_verifies = 6;
  localparam int num_words    = `GFX_HRES * `GFX_VRES;
  // worst case a few cycles per box pixel, a full clear, four cycles per readback word
  localparam int wd_cycles    = num_entries * 8 * num_words + num_clears * (num_words + 64)
                                + num_verifies * 4 * num_words + 500;

  typedef struct packed {
    gfx_pkg::triangle_t t;
    logic               clear_first;  // clear with clr before drawing
    logic [`GFX_CW-1:0] clr;
    logic               burst;        // next triangle goes out without waiting
    logic               changes;      // some pixel should change
    logic               verify;       // read the whole frame afterwards
  } entry_t;

  logic                 clk_in = 1'b0;
  logic                 rst;
  logic                 tri_valid;
  gfx_pkg::triangle_t   tri_data;
  logic                 tri_ready;
  logic                 clear_start;
  logic [`GFX_CW-1:0]   clear_color;
  logic                 clear_busy;
  logic                 rd_valid;
  logic [`GFX_AW-1:0]   rd_addr;
  logic                 rd_ready;
  logic                 rd_data_valid;
  gfx_pkg::fb_word_t    rd_data;
  logic                 draw_done;

  entry_t               tab [num_entries];
  gfx_pkg::fb_word_t    model [num_words];  // expected z and color per pixel
  int                   done_cnt;
  int                   sent;
  logic                 rd_taken;

  gfx_top i_dut (
    .clk_in(clk_in), .rst(rst),
    .tri_valid(tri_valid), .tri_data(tri_data), .tri_ready(tri_ready),
    .clear_start(clear_start), .clear_color(clear_color), .clear_busy(clear_busy),
    .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_ready(rd_ready),
    .rd_data_valid(rd_data_valid), .rd_data(rd_data), .draw_done(draw_done)
  );

  always #50 clk_in = ~clk_in;

  always @(posedge clk_in) begin
    if (rst) done_cnt <= 0;
    else if (draw_done) done_cnt <= done_cnt + 1;  // one pulse per retired triangle
  end

  // readout request accepted on the last rising edge
  always @(posedge clk_in) begin
    if (rst) rd_taken <= 1'b0;
    else rd_taken <= rd_valid && rd_ready;
  end

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_word(input gfx_pkg::fb_word_t got, input gfx_pkg::fb_word_t exp,
                            input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s: got z=%02h color=%02h, expected z=%02h color=%02h",
                                what, got.z, got.color, exp.z, exp.color));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
  endtask

  // cross product of a->b and a->p, not negative inside a ccw triangle
  function automatic int side_of(input int ax, input int ay, input int bx, input int by,
                                 input int px, input int py);
    return (bx - ax) * (py - ay) - (by - ay) * (px - ax);
  endfunction

  task automatic model_draw(input gfx_pkg::triangle_t t, output logic changed);
    int vx [3];
    int vy [3];
    int area, z, tmp, adr;
    int xlo, xhi, ylo, yhi;
    changed = 1'b0;
    for (int k = 0; k < 3; k++) begin
      vx[k] = t.v[k].x;
      vy[k] = t.v[k].y;
    end
    area = side_of(vx[0], vy[0], vx[1], vy[1], vx[2], vy[2]);
    if (area < 0) begin  // clockwise, swap 1 and 2
      tmp   = vx[1];
      vx[1] = vx[2];
      vx[2] = tmp;
      tmp   = vy[1];
      vy[1] = vy[2];
      vy[2] = tmp;
    end
    z   = t.v[0].z;
    xlo = vx[0];
    xhi = vx[0];
    ylo = vy[0];
    yhi = vy[0];
    for (int k = 1; k < 3; k++) begin
      if (t.v[k].z < z) z = t.v[k].z;  // flat depth is the nearest vertex
      if (vx[k] < xlo) xlo = vx[k];
      if (vx[k] > xhi) xhi = vx[k];
      if (vy[k] < ylo) ylo = vy[k];
      if (vy[k] > yhi) yhi = vy[k];
    end
    if (xlo < 0) xlo = 0;
    if (ylo < 0) ylo = 0;
    if (xhi > `GFX_HRES - 1) xhi = `GFX_HRES - 1;
    if (yhi > `GFX_VRES - 1) yhi = `GFX_VRES - 1;
    if (area != 0) begin
      for (int y = ylo; y <= yhi; y++) begin
        for (int x = xlo; x <= xhi; x++) begin
          if (side_of(vx[0], vy[0], vx[1], vy[1], x, y) >= 0 &&
              side_of(vx[1], vy[1], vx[2], vy[2], x, y) >= 0 &&
              side_of(vx[2], vy[2], vx[0], vy[0], x, y) >= 0) begin
            adr = y * `GFX_HRES + x;
            if (z < model[adr].z) begin  // strictly nearer only
              model[adr].z     = `GFX_ZW'(z);
              model[adr].color = t.color;
              changed          = 1'b1;
            end
          end
        end
      end
    end
  endtask

  function automatic gfx_pkg::triangle_t mk_tri(input int x0, input int y0, input int z0,
                                                input int x1, input int y1, input int z1,
                                                input int x2, input int y2, input int z2,
                                                input logic [`GFX_CW-1:0] color);
    gfx_pkg::triangle_t t;
    t.v[0]  = {`GFX_XW'(x0), `GFX_YW'(y0), `GFX_ZW'(z0)};
    t.v[1]  = {`GFX_XW'(x1), `GFX_YW'(y1), `GFX_ZW'(z1)};
    t.v[2]  = {`GFX_XW'(x2), `GFX_YW'(y2), `GFX_ZW'(z2)};
    t.color = color;
    return t;
  endfunction

  task automatic set_entry(input int i, input gfx_pkg::triangle_t t, input logic cf,
                           input logic [`GFX_CW-1:0] clr, input logic burst,
                           input logic changes, input logic verify);
    tab[i] = {t, cf, clr, burst, changes, verify};
  endtask

  task automatic fill_table();
    // ccw, then the same triangle clockwise
    set_entry(0, mk_tri(4, 4, 40, 20, 6, 60, 10, 24, 50, 8'ha1), 1, 8'h11, 0, 1, 1);
    set_entry(1, mk_tri(4, 4, 40, 10, 24, 50, 20, 6, 60, 8'ha1), 1, 8'h11, 0, 1, 1);
    // far, near, farther, then equal depth
    set_entry(2, mk_tri(2, 2, 100, 28, 4, 120, 14, 28, 110, 8'hb2), 1, 8'h22, 0, 1, 0);
    set_entry(3, mk_tri(6, 6, 60, 24, 10, 70, 12, 22, 50, 8'hc3), 0, 8'h22, 0, 1, 0);
    set_entry(4, mk_tri(8, 8, 150, 20, 8, 150, 14, 18, 150, 8'hd4), 0, 8'h22, 0, 0, 0);
    set_entry(5, mk_tri(6, 6, 50, 24, 10, 50, 12, 22, 50, 8'he5), 0, 8'h22, 0, 0, 1);
    // reverse order, then degenerate ones
    set_entry(6, mk_tri(6, 6, 60, 24, 10, 70, 12, 22, 50, 8'hc3), 1, 8'h22, 0, 1, 0);
    set_entry(7, mk_tri(2, 2, 100, 28, 4, 120, 14, 28, 110, 8'hb2), 0, 8'h22, 0, 1, 0);
    set_entry(8, mk_tri(8, 8, 150, 20, 8, 150, 14, 18, 150, 8'hd4), 0, 8'h22, 0, 0, 0);
    set_entry(9, mk_tri(0, 0, 5, 10, 10, 5, 20, 20, 5, 8'h0f), 0, 8'h22, 0, 0, 0);
    set_entry(10, mk_tri(7, 7, 1, 7, 7, 1, 7, 7, 1, 8'h0e), 0, 8'h22, 0, 0, 0);
    set_entry(11, mk_tri(0, 31, 3, 31, 31, 3, 15, 31, 3, 8'h0d), 0, 8'h22, 0, 0, 1);
    // back to back while earlier ones still draw
    set_entry(12, mk_tri(0, 0, 200, 31, 0, 200, 0, 31, 200, 8'h61), 1, 8'h5a, 1, 1, 0);
    set_entry(13, mk_tri(31, 31, 90, 31, 0, 90, 0, 31, 90, 8'h72), 0, 8'h5a, 1, 1, 0);
    set_entry(14, mk_tri(10, 10, 10, 16, 12, 20, 12, 18, 30, 8'h83), 0, 8'h5a, 1, 1, 0);
    set_entry(15, mk_tri(3, 3, 0, 3, 3, 0, 9, 9, 0, 8'h94), 0, 8'h5a, 1, 0, 0);
    set_entry(16, mk_tri(5, 20, 255, 25, 22, 255, 15, 30, 255, 8'ha5), 0, 8'h5a, 1, 0, 1);
  endtask

  // all driving tasks start and end on a falling edge
  task automatic do_clear(input logic [`GFX_CW-1:0] color);
    int n;
    clear_start = 1'b1;
    clear_color = color;
    @(negedge clk_in);
    clear_start = 1'b0;
    check_flag(clear_busy, 1'b1, "clear_busy after clear_start");
    n = 0;
    while (clear_busy) begin
      n++;
      @(negedge clk_in);
    end
    check_flag(n == num_words, 1'b1, $sformatf("clear_busy high for %0d cycles", n));
    for (int a = 0; a < num_words; a++) begin
      model[a].z     = `GFX_ZMAX;
      model[a].color = color;
    end
  endtask

  task automatic read_word(input int adr, output gfx_pkg::fb_word_t w);
    rd_valid = 1'b1;
    rd_addr  = `GFX_AW'(adr);
    @(negedge clk_in);
    while (!rd_taken) begin  // held off by a higher priority peer
      check_flag(rd_data_valid, 1'b0, "rd_data_valid before the read was accepted");
      @(negedge clk_in);
    end
    rd_valid = 1'b0;
    check_flag(rd_data_valid, 1'b1, "rd_data_valid in the cycle after rd_ready");
    w = rd_data;
  endtask

  task automatic verify_frame(input string label);
    gfx_pkg::fb_word_t w;
    for (int a = 0; a < num_words; a++) begin
      repeat ($urandom_range(2, 0)) @(negedge clk_in);
      read_word(a, w);
      check_word(w, model[a], $sformatf("%s, pixel x=%0d y=%0d", label,
                                        a % `GFX_HRES, a / `GFX_HRES));
    end
  endtask

  task automatic send_tri(input gfx_pkg::triangle_t t);
    tri_valid = 1'b1;
    tri_data  = t;
    while (!tri_ready) @(negedge clk_in);  // stalled behind a waiting job
    @(negedge clk_in);
    tri_valid = 1'b0;
  endtask

  task automatic wait_done(input int target);
    while (done_cnt < target) @(negedge clk_in);
  endtask

  initial begin
    logic changed;
    void'($urandom(74708));
    rst         = 1'b1;
    tri_valid   = 1'b0;
    tri_data    = '0;
    clear_start = 1'b0;
    clear_color = '0;
    rd_valid    = 1'b0;
    rd_addr     = '0;
    sent        = 0;
    fill_table();
    repeat (10) @(negedge clk_in);
    rst = 1'b0;
    check_flag(draw_done, 1'b0, "draw_done after reset");
    check_flag(clear_busy, 1'b0, "clear_busy after reset");
    check_flag(rd_data_valid, 1'b0, "rd_data_valid after reset");

    do_clear(8'h3c);
    verify_frame("first clear");

    for (int i = 0; i < num_entries; i++) begin
      if (tab[i].clear_first) begin
        wait_done(sent);
        do_clear(tab[i].clr);
      end
      model_draw(tab[i].t, changed);
      check_flag(changed, tab[i].changes, $sformatf("model change flag of entry %0d", i));
      send_tri(tab[i].t);
      sent++;
      if (!tab[i].burst) wait_done(sent);
      if (tab[i].verify) begin
        wait_done(sent);
        repeat (4) @(negedge clk_in);
        check_flag(done_cnt == sent, 1'b1, $sformatf("draw_done count %0d", done_cnt));
        verify_frame($sformatf("after entry %0d", i));
      end
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    #(wd_cycles * 100);
    $display("timeout: the run did not finish within %0d clock cycles", wd_cycles);
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
gfx_pkg.sv
tri_setup.sv
tri_raster.sv
depth_test.sv
frame_clear.sv
fb_arbiter.sv
fb_mem.sv
gfx_top.sv
gfx_tb.sv
